// ==== build.f ====
verilog/pspin_pkg.sv
verilog/her_intake.sv
verilog/task_scheduler.sv
verilog/feedback_arbiter.sv
verilog/pspin_top.sv
test/tb_clock_gen.sv
test/pspin_chk.sv
test/pspin_tb.sv

// ==== test/pspin_tb.sv ====
`timescale 1ns/1ps
// ******************************
// Dispatch core testbench
// Directed tests of intake, slots,
// feedback and MPQ ordering
// ******************************

module pspin_tb import pspin_pkg::*; ();

  localparam int unsigned RESET_CYCLES = 10;
  localparam int unsigned NUM_TESTS = 6;
  localparam int unsigned CLK_PERIOD = 100;
  localparam int unsigned TIMEOUT_CYCLES = NUM_TESTS * (200 + RESET_CYCLES);
  localparam int unsigned TOTAL_SLOTS = NUM_CLUSTERS * SLOTS_PER_CLUSTER;
  localparam logic [31:0] SEED = 32'h2cc9821b;

  logic                                    clk;
  logic                                    rst_n = 1'b0;
  logic                                    her_valid = 1'b0;
  logic [MPQ_IDX_W-1:0]                    her_mpq = '0;
  logic [PKT_ADDR_W-1:0]                   her_addr = '0;
  logic [PKT_LEN_W-1:0]                    her_len = '0;
  logic [NUM_CLUSTERS-1:0]                 task_ready = '0;
  logic [NUM_CLUSTERS-1:0]                 fb_valid = '0;
  logic [NUM_CLUSTERS-1:0][MPQ_IDX_W-1:0]  fb_mpq = '0;
  logic [NUM_CLUSTERS-1:0][PKT_ADDR_W-1:0] fb_addr = '0;
  logic                                    nic_ready = 1'b1;

  logic                                    her_ready;
  logic [NUM_MPQ-1:0]                      mpq_full;
  logic [NUM_CLUSTERS-1:0]                 task_valid;
  logic [NUM_CLUSTERS-1:0][MPQ_IDX_W-1:0]  task_mpq;
  logic [NUM_CLUSTERS-1:0][PKT_ADDR_W-1:0] task_addr;
  logic [NUM_CLUSTERS-1:0][PKT_LEN_W-1:0]  task_len;
  logic [NUM_CLUSTERS-1:0]                 fb_ready;
  logic                                    nic_valid;
  logic [CLUSTER_IDX_W-1:0]                nic_cluster;
  logic [MPQ_IDX_W-1:0]                    nic_mpq;
  logic [PKT_ADDR_W-1:0]                   nic_addr;
  logic                                    active;

  // Tasks taken by the cluster model, in transfer order
  logic [MPQ_IDX_W-1:0]  seen_mpq [$];
  logic [PKT_ADDR_W-1:0] seen_addr [$];
  logic [PKT_LEN_W-1:0]  seen_len [$];

  int task_errors = 0;
  int feedback_errors = 0;
  int flag_errors = 0;

  tb_clock_gen clock_gen_inst (.clk_o(clk));

  pspin_top pspin_top_inst (
    .clk_i                    (clk),
    .rst_ni                   (rst_n),
    .her_valid_i              (her_valid),
    .her_mpq_i                (her_mpq),
    .her_addr_i               (her_addr),
    .her_len_i                (her_len),
    .her_ready_o              (her_ready),
    .mpq_full_o               (mpq_full),
    .cluster_task_valid_o     (task_valid),
    .cluster_task_ready_i     (task_ready),
    .cluster_task_mpq_o       (task_mpq),
    .cluster_task_addr_o      (task_addr),
    .cluster_task_len_o       (task_len),
    .cluster_feedback_valid_i (fb_valid),
    .cluster_feedback_ready_o (fb_ready),
    .cluster_feedback_mpq_i   (fb_mpq),
    .cluster_feedback_addr_i  (fb_addr),
    .nic_feedback_valid_o     (nic_valid),
    .nic_feedback_ready_i     (nic_ready),
    .nic_feedback_cluster_o   (nic_cluster),
    .nic_feedback_mpq_o       (nic_mpq),
    .nic_feedback_addr_o      (nic_addr),
    .pspin_active_o           (active)
  );

  task compare_task(input logic [MPQ_IDX_W-1:0] got_mpq, input logic [PKT_ADDR_W-1:0] got_addr,
                    input logic [PKT_LEN_W-1:0] got_len, input logic [MPQ_IDX_W-1:0] exp_mpq,
                    input logic [PKT_ADDR_W-1:0] exp_addr, input logic [PKT_LEN_W-1:0] exp_len,
                    input string what);
    if (got_mpq !== exp_mpq || got_addr !== exp_addr || got_len !== exp_len) begin
      task_errors++;
      $display("error at %0t: %s, got mpq %0d addr %h len %0d, expected mpq %0d addr %h len %0d",
               $time, what, got_mpq, got_addr, got_len, exp_mpq, exp_addr, exp_len);
    end
  endtask

  task compare_feedback(input logic [CLUSTER_IDX_W-1:0] got_cluster,
                        input logic [MPQ_IDX_W-1:0] got_mpq, input logic [PKT_ADDR_W-1:0] got_addr,
                        input logic [CLUSTER_IDX_W-1:0] exp_cluster,
                        input logic [MPQ_IDX_W-1:0] exp_mpq, input logic [PKT_ADDR_W-1:0] exp_addr);
    if (got_cluster !== exp_cluster || got_mpq !== exp_mpq || got_addr !== exp_addr) begin
      feedback_errors++;
      $display("error at %0t: nic feedback got cluster %0d mpq %0d addr %h, expected %0d %0d %h",
               $time, got_cluster, got_mpq, got_addr, exp_cluster, exp_mpq, exp_addr);
    end
  endtask

  task compare_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      flag_errors++;
      $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task compare_mask(input logic [NUM_CLUSTERS-1:0] got, input logic [NUM_CLUSTERS-1:0] exp,
                    input string what);
    if (got !== exp) begin
      flag_errors++;
      $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task apply_reset();
    @(posedge clk);
    rst_n      <= 1'b0;
    her_valid  <= 1'b0;
    task_ready <= '0;
    fb_valid   <= '0;
    nic_ready  <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    seen_mpq.delete();
    seen_addr.delete();
    seen_len.delete();
    @(negedge clk);
  endtask

  task send_her(input logic [MPQ_IDX_W-1:0] mpq, input logic [PKT_ADDR_W-1:0] addr,
                input logic [PKT_LEN_W-1:0] len);
    @(posedge clk);
    her_valid <= 1'b1;
    her_mpq   <= mpq;
    her_addr  <= addr;
    her_len   <= len;
    do @(negedge clk); while (!her_ready);
    @(posedge clk);
    her_valid <= 1'b0;
  endtask

  task send_feedback(input int c, input logic [MPQ_IDX_W-1:0] mpq,
                     input logic [PKT_ADDR_W-1:0] addr);
    @(posedge clk);
    fb_valid[c] <= 1'b1;
    fb_mpq[c]   <= mpq;
    fb_addr[c]  <= addr;
    do @(negedge clk); while (!fb_ready[c]);
    @(posedge clk);
    fb_valid[c] <= 1'b0;
  endtask

  // Waits for the next task at any cluster and checks where it landed
  task expect_task(input int c, input logic [MPQ_IDX_W-1:0] mpq,
                   input logic [PKT_ADDR_W-1:0] addr, input logic [PKT_LEN_W-1:0] len,
                   input string what);
    do @(negedge clk); while (task_valid == '0);
    compare_mask(task_valid, NUM_CLUSTERS'(1) << c, what);
    compare_task(task_mpq[c], task_addr[c], task_len[c], mpq, addr, len, what);
  endtask

  task test_reset();
    apply_reset();
    compare_mask(task_valid, '0, "cluster task valid after reset");
    compare_flag(nic_valid, 1'b0, "nic feedback valid after reset");
    compare_flag(active, 1'b0, "active flag after reset");
    compare_flag(|mpq_full, 1'b0, "mpq full flags after reset");
    compare_flag(her_ready, 1'b1, "her ready after reset");
  endtask

  task test_single_dispatch();
    logic [PKT_ADDR_W-1:0] addr;
    logic [PKT_LEN_W-1:0]  len;
    apply_reset();
    addr = PKT_ADDR_W'($urandom);
    len  = PKT_LEN_W'($urandom);
    @(posedge clk);
    task_ready <= '1;
    send_her(MPQ_IDX_W'(2), addr, len);
    expect_task(0, MPQ_IDX_W'(2), addr, len, "single dispatch");
  endtask

  task test_full_flags();
    apply_reset();
    // Four tasks park in the cluster registers, the rest fill MPQ 1
    for (int i = 0; i < NUM_CLUSTERS + MPQ_DEPTH; i++) begin
      send_her(MPQ_IDX_W'(1), PKT_ADDR_W'($urandom), PKT_LEN_W'($urandom));
    end
    @(negedge clk);
    compare_mask(task_valid, '1, "cluster task valid while blocked");
    for (int m = 0; m < NUM_MPQ; m++) begin
      compare_flag(mpq_full[m], m == 1, "mpq full flag");
    end
    @(posedge clk);
    her_mpq <= MPQ_IDX_W'(1);
    @(negedge clk);
    compare_flag(her_ready, 1'b0, "her ready for full mpq 1");
    @(posedge clk);
    her_mpq <= MPQ_IDX_W'(2);
    @(negedge clk);
    compare_flag(her_ready, 1'b1, "her ready for open mpq 2");
  endtask

  task test_slots();
    logic [PKT_ADDR_W-1:0] addr;
    logic [PKT_LEN_W-1:0]  len;
    apply_reset();
    @(posedge clk);
    task_ready <= '1;
    for (int i = 0; i < TOTAL_SLOTS; i++) begin
      send_her('0, PKT_ADDR_W'($urandom), PKT_LEN_W'($urandom));
    end
    addr = PKT_ADDR_W'($urandom);
    len  = PKT_LEN_W'($urandom);
    send_her(MPQ_IDX_W'(1), addr, len);
    while (seen_mpq.size() < TOTAL_SLOTS) @(negedge clk);
    // The extra task has to stay queued while no slot is free
    repeat (10) @(negedge clk);
    compare_flag(seen_mpq.size() == TOTAL_SLOTS, 1'b1, "task count with all slots used");
    compare_mask(task_valid, '0, "cluster task valid with all slots used");
    compare_flag(active, 1'b1, "active flag with all slots used");
    send_feedback(2, '0, '0);
    expect_task(2, MPQ_IDX_W'(1), addr, len, "task after slot release");
  endtask

  task test_feedback();
    logic [NUM_CLUSTERS-1:0]                 pending;
    logic [NUM_CLUSTERS-1:0]                 accepted;
    logic [NUM_CLUSTERS-1:0]                 delivered;
    logic [NUM_CLUSTERS-1:0][MPQ_IDX_W-1:0]  exp_mpq;
    logic [NUM_CLUSTERS-1:0][PKT_ADDR_W-1:0] exp_addr;
    logic [CLUSTER_IDX_W-1:0]                k;
    int                                      taken;
    apply_reset();
    // Low address bits name the source cluster
    for (int c = 0; c < NUM_CLUSTERS; c++) begin
      exp_mpq[c]  = MPQ_IDX_W'($urandom);
      exp_addr[c] = (PKT_ADDR_W'($urandom) << CLUSTER_IDX_W) | PKT_ADDR_W'(c);
    end
    pending   = '1;
    delivered = '0;
    taken     = 0;
    @(posedge clk);
    fb_valid  <= pending;
    fb_mpq    <= exp_mpq;
    fb_addr   <= exp_addr;
    nic_ready <= 1'b0;
    while (taken < NUM_CLUSTERS) begin
      @(negedge clk);
      if (nic_valid && nic_ready) begin
        k = nic_addr[CLUSTER_IDX_W-1:0];
        if (delivered[k]) begin
          feedback_errors++;
          $display("error at %0t: feedback of cluster %0d reached the NIC twice", $time, k);
        end
        delivered[k] = 1'b1;
        compare_feedback(nic_cluster, nic_mpq, nic_addr, k, exp_mpq[k], exp_addr[k]);
        taken++;
      end
      accepted = pending & fb_ready;
      @(posedge clk);
      pending = pending & ~accepted;
      fb_valid  <= pending;
      nic_ready <= 1'($urandom);
    end
    @(posedge clk);
    nic_ready <= 1'b1;
    @(negedge clk);
    compare_mask(delivered, '1, "clusters with feedback at the NIC");
    compare_flag(nic_valid, 1'b0, "nic feedback valid after drain");
  endtask

  task test_round_robin();
    logic [PKT_ADDR_W-1:0] rr_addr [2][MPQ_DEPTH];
    logic [PKT_LEN_W-1:0]  rr_len  [2][MPQ_DEPTH];
    apply_reset();
    // Interleaved arrivals on MPQ 0 and 3 with every cluster blocked
    for (int i = 0; i < MPQ_DEPTH; i++) begin
      for (int j = 0; j < 2; j++) begin
        rr_addr[j][i] = PKT_ADDR_W'($urandom);
        rr_len[j][i]  = PKT_LEN_W'($urandom);
        send_her(MPQ_IDX_W'(3 * j), rr_addr[j][i], rr_len[j][i]);
      end
    end
    @(posedge clk);
    task_ready <= '1;
    while (seen_mpq.size() < 2 * MPQ_DEPTH) @(negedge clk);
    for (int n = 0; n < 2 * MPQ_DEPTH; n++) begin
      compare_task(seen_mpq[n], seen_addr[n], seen_len[n], MPQ_IDX_W'(3 * (n % 2)),
                   rr_addr[n % 2][n / 2], rr_len[n % 2][n / 2], "round-robin order");
    end
  endtask

  // Cluster model, records each accepted task
  always @(negedge clk) begin
    if (rst_n) begin
      for (int c = 0; c < NUM_CLUSTERS; c++) begin
        if (task_valid[c] && task_ready[c]) begin
          seen_mpq.push_back(task_mpq[c]);
          seen_addr.push_back(task_addr[c]);
          seen_len.push_back(task_len[c]);
        end
      end
    end
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("tests failed");
    $finish;
  end

  initial begin
    int assert_errors;
    void'($urandom(SEED));
    test_reset();
    test_single_dispatch();
    test_full_flags();
    test_slots();
    test_feedback();
    test_round_robin();
    assert_errors = pspin_top_inst.pspin_chk_inst.fail_count;
    $display("errors: task %0d, feedback %0d, flag %0d, assertion %0d",
             task_errors, feedback_errors, flag_errors, assert_errors);
    if (task_errors + feedback_errors + flag_errors + assert_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== test/pspin_chk.sv ====
`timescale 1ns/1ps
// ******************************
// Protocol checker for the
// dispatch core top level
// ******************************

module pspin_chk import pspin_pkg::*; (
  input logic                                    clk_i,
  input logic                                    rst_ni,
  input logic                                    her_valid_i,
  input logic [MPQ_IDX_W-1:0]                    her_mpq_i,
  input logic                                    her_ready_o,
  input logic [NUM_MPQ-1:0]                      mpq_full_o,
  input logic [NUM_CLUSTERS-1:0]                 cluster_task_valid_o,
  input logic [NUM_CLUSTERS-1:0]                 cluster_task_ready_i,
  input logic [NUM_CLUSTERS-1:0][MPQ_IDX_W-1:0]  cluster_task_mpq_o,
  input logic [NUM_CLUSTERS-1:0][PKT_ADDR_W-1:0] cluster_task_addr_o,
  input logic [NUM_CLUSTERS-1:0][PKT_LEN_W-1:0]  cluster_task_len_o,
  input logic                                    nic_feedback_valid_o,
  input logic                                    nic_feedback_ready_i,
  input logic [CLUSTER_IDX_W-1:0]                nic_feedback_cluster_o,
  input logic [MPQ_IDX_W-1:0]                    nic_feedback_mpq_o,
  input logic [PKT_ADDR_W-1:0]                   nic_feedback_addr_o
);

  // Number of failed assertions
  int unsigned fail_count = 0;

  // A stalled cluster task keeps its valid and its fields
  for (genvar c = 0; c < NUM_CLUSTERS; c++) begin : gen_task_hold
    task_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      cluster_task_valid_o[c] && !cluster_task_ready_i[c] |=>
        cluster_task_valid_o[c] && $stable(cluster_task_mpq_o[c]) &&
        $stable(cluster_task_addr_o[c]) && $stable(cluster_task_len_o[c]))
      else begin
        $error("cluster %0d task changed while stalled", c);
        fail_count++;
      end
  end

  feedback_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    nic_feedback_valid_o && !nic_feedback_ready_i |=>
      nic_feedback_valid_o && $stable(nic_feedback_cluster_o) &&
      $stable(nic_feedback_mpq_o) && $stable(nic_feedback_addr_o))
    else begin
      $error("nic feedback changed while stalled");
      fail_count++;
    end

  // A queue only turns full on a HER accepted into it
  for (genvar m = 0; m < NUM_MPQ; m++) begin : gen_full_rise
    full_rise: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $rose(mpq_full_o[m]) |->
        $past(her_valid_i && her_ready_o && (her_mpq_i == MPQ_IDX_W'(m))))
      else begin
        $error("mpq %0d turned full without an accepted her", m);
        fail_count++;
      end
  end

endmodule

bind pspin_top pspin_chk pspin_chk_inst (.*);

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps
// ******************************
// Testbench clock source
// Free-running 100 ns clock
// ******************************

module tb_clock_gen (
  output logic clk_o
);

  localparam time HALF_PERIOD = 50ns;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

endmodule

// ==== verilog/pspin_top.sv ====
`timescale 1ns/1ps
// ******************************
// Dispatch core top level
// HER intake, task scheduler and
// feedback arbiter
// ******************************

module pspin_top import pspin_pkg::*; (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // NIC side, HERs in
  input  logic                                     her_valid_i,
  input  logic [MPQ_IDX_W-1:0]                     her_mpq_i,
  input  logic [PKT_ADDR_W-1:0]                    her_addr_i,
  input  logic [PKT_LEN_W-1:0]                     her_len_i,
  output logic                                     her_ready_o,
  output logic [NUM_MPQ-1:0]                       mpq_full_o,
  // Cluster task ports
  output logic [NUM_CLUSTERS-1:0]                  cluster_task_valid_o,
  input  logic [NUM_CLUSTERS-1:0]                  cluster_task_ready_i,
  output logic [NUM_CLUSTERS-1:0][MPQ_IDX_W-1:0]   cluster_task_mpq_o,
  output logic [NUM_CLUSTERS-1:0][PKT_ADDR_W-1:0]  cluster_task_addr_o,
  output logic [NUM_CLUSTERS-1:0][PKT_LEN_W-1:0]   cluster_task_len_o,
  // Cluster feedback ports
  input  logic [NUM_CLUSTERS-1:0]                  cluster_feedback_valid_i,
  output logic [NUM_CLUSTERS-1:0]                  cluster_feedback_ready_o,
  input  logic [NUM_CLUSTERS-1:0][MPQ_IDX_W-1:0]   cluster_feedback_mpq_i,
  input  logic [NUM_CLUSTERS-1:0][PKT_ADDR_W-1:0]  cluster_feedback_addr_i,
  // NIC side, feedback out
  output logic                                     nic_feedback_valid_o,
  input  logic                                     nic_feedback_ready_i,
  output logic [CLUSTER_IDX_W-1:0]                 nic_feedback_cluster_o,
  output logic [MPQ_IDX_W-1:0]                     nic_feedback_mpq_o,
  output logic [PKT_ADDR_W-1:0]                    nic_feedback_addr_o,
  output logic                                     pspin_active_o
);

  // Intake to scheduler
  logic                     task_valid;
  logic                     task_ready;
  logic [MPQ_IDX_W-1:0]     task_mpq;
  logic [PKT_ADDR_W-1:0]    task_addr;
  logic [PKT_LEN_W-1:0]     task_len;

  // Arbiter to scheduler
  logic                     slot_free_valid;
  logic [CLUSTER_IDX_W-1:0] slot_free_cluster;

  her_intake i_her_intake (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .her_valid_i  (her_valid_i),
    .her_mpq_i    (her_mpq_i),
    .her_addr_i   (her_addr_i),
    .her_len_i    (her_len_i),
    .her_ready_o  (her_ready_o),
    .mpq_full_o   (mpq_full_o),
    .task_valid_o (task_valid),
    .task_ready_i (task_ready),
    .task_mpq_o   (task_mpq),
    .task_addr_o  (task_addr),
    .task_len_o   (task_len)
  );

  task_scheduler i_task_scheduler (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .task_valid_i         (task_valid),
    .task_ready_o         (task_ready),
    .task_mpq_i           (task_mpq),
    .task_addr_i          (task_addr),
    .task_len_i           (task_len),
    .cluster_task_valid_o (cluster_task_valid_o),
    .cluster_task_ready_i (cluster_task_ready_i),
    .cluster_task_mpq_o   (cluster_task_mpq_o),
    .cluster_task_addr_o  (cluster_task_addr_o),
    .cluster_task_len_o   (cluster_task_len_o),
    .slot_free_valid_i    (slot_free_valid),
    .slot_free_cluster_i  (slot_free_cluster),
    .pspin_active_o       (pspin_active_o)
  );

  feedback_arbiter i_feedback_arbiter (
    .clk_i                    (clk_i),
    .rst_ni                   (rst_ni),
    .cluster_feedback_valid_i (cluster_feedback_valid_i),
    .cluster_feedback_ready_o (cluster_feedback_ready_o),
    .cluster_feedback_mpq_i   (cluster_feedback_mpq_i),
    .cluster_feedback_addr_i  (cluster_feedback_addr_i),
    .nic_feedback_valid_o     (nic_feedback_valid_o),
    .nic_feedback_ready_i     (nic_feedback_ready_i),
    .nic_feedback_cluster_o   (nic_feedback_cluster_o),
    .nic_feedback_mpq_o       (nic_feedback_mpq_o),
    .nic_feedback_addr_o      (nic_feedback_addr_o),
    .slot_free_valid_o        (slot_free_valid),
    .slot_free_cluster_o      (slot_free_cluster)
  );

endmodule

// ==== verilog/feedback_arbiter.sv ====
`timescale 1ns/1ps
// ******************************
// Feedback arbiter
// Round-robin merge of cluster
// feedback into one NIC stream,
// releases the handler slot
// ******************************

module feedback_arbiter import pspin_pkg::*; (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // Feedback from the clusters
  input  logic [NUM_CLUSTERS-1:0]                  cluster_feedback_valid_i,
  output logic [NUM_CLUSTERS-1:0]                  cluster_feedback_ready_o,
  input  logic [NUM_CLUSTERS-1:0][MPQ_IDX_W-1:0]   cluster_feedback_mpq_i,
  input  logic [NUM_CLUSTERS-1:0][PKT_ADDR_W-1:0]  cluster_feedback_addr_i,
  // Registered feedback to the NIC
  output logic                                     nic_feedback_valid_o,
  input  logic                                     nic_feedback_ready_i,
  output logic [CLUSTER_IDX_W-1:0]                 nic_feedback_cluster_o,
  output logic [MPQ_IDX_W-1:0]                     nic_feedback_mpq_o,
  output logic [PKT_ADDR_W-1:0]                    nic_feedback_addr_o,
  // Slot release to the scheduler
  output logic                                     slot_free_valid_o,
  output logic [CLUSTER_IDX_W-1:0]                 slot_free_cluster_o
);

  logic [CLUSTER_IDX_W-1:0] last_q;
  logic [CLUSTER_IDX_W-1:0] grant;
  logic                     can_accept;
  logic                     accept;
  logic                     valid_q;
  logic [CLUSTER_IDX_W-1:0] cluster_q;
  logic [MPQ_IDX_W-1:0]     mpq_q;
  logic [PKT_ADDR_W-1:0]    addr_q;

  // Requester closest after the last grant
  always_comb begin
    logic [CLUSTER_IDX_W-1:0] idx;
    grant = last_q;
    idx   = last_q;
    for (int k = NUM_CLUSTERS; k >= 1; k--) begin
      idx = last_q + CLUSTER_IDX_W'(k);
      if (cluster_feedback_valid_i[idx]) begin
        grant = idx;
      end
    end
  end

  // Output register free now or drained this cycle
  assign can_accept = !valid_q || nic_feedback_ready_i;
  assign accept     = (|cluster_feedback_valid_i) && can_accept;

  for (genvar c = 0; c < NUM_CLUSTERS; c++) begin : gen_ready
    assign cluster_feedback_ready_o[c] = can_accept && (grant == CLUSTER_IDX_W'(c));
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      last_q  <= CLUSTER_IDX_W'(NUM_CLUSTERS - 1);
    end else if (accept) begin
      valid_q <= 1'b1;
      last_q  <= grant;
    end else if (nic_feedback_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      cluster_q <= grant;
      mpq_q     <= cluster_feedback_mpq_i[grant];
      addr_q    <= cluster_feedback_addr_i[grant];
    end
  end

  assign nic_feedback_valid_o   = valid_q;
  assign nic_feedback_cluster_o = cluster_q;
  assign nic_feedback_mpq_o     = mpq_q;
  assign nic_feedback_addr_o    = addr_q;

  // One pulse per accepted feedback
  assign slot_free_valid_o   = accept;
  assign slot_free_cluster_o = grant;

endmodule

// ==== verilog/task_scheduler.sv ====
`timescale 1ns/1ps
// ******************************
// Task scheduler
// Hands tasks to the clusters,
// counts used handler slots and
// flags when all clusters work
// ******************************

module task_scheduler import pspin_pkg::*; (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // Tasks from the intake
  input  logic                                     task_valid_i,
  output logic                                     task_ready_o,
  input  logic [MPQ_IDX_W-1:0]                     task_mpq_i,
  input  logic [PKT_ADDR_W-1:0]                    task_addr_i,
  input  logic [PKT_LEN_W-1:0]                     task_len_i,
  // Task registers towards the clusters
  output logic [NUM_CLUSTERS-1:0]                  cluster_task_valid_o,
  input  logic [NUM_CLUSTERS-1:0]                  cluster_task_ready_i,
  output logic [NUM_CLUSTERS-1:0][MPQ_IDX_W-1:0]   cluster_task_mpq_o,
  output logic [NUM_CLUSTERS-1:0][PKT_ADDR_W-1:0]  cluster_task_addr_o,
  output logic [NUM_CLUSTERS-1:0][PKT_LEN_W-1:0]   cluster_task_len_o,
  // Slot release from the feedback arbiter
  input  logic                                     slot_free_valid_i,
  input  logic [CLUSTER_IDX_W-1:0]                 slot_free_cluster_i,
  output logic                                     pspin_active_o
);

  logic [NUM_CLUSTERS-1:0]                 valid_q;
  logic [NUM_CLUSTERS-1:0][MPQ_IDX_W-1:0]  mpq_q;
  logic [NUM_CLUSTERS-1:0][PKT_ADDR_W-1:0] addr_q;
  logic [NUM_CLUSTERS-1:0][PKT_LEN_W-1:0]  len_q;
  logic [SLOT_CNT_W-1:0]                   used_q [NUM_CLUSTERS];

  logic [NUM_CLUSTERS-1:0]  avail;
  logic [NUM_CLUSTERS-1:0]  in_use;
  logic [NUM_CLUSTERS-1:0]  take_vec;
  logic [NUM_CLUSTERS-1:0]  free_vec;
  logic [CLUSTER_IDX_W-1:0] target;
  logic                     take;
  logic                     active_q;

  for (genvar c = 0; c < NUM_CLUSTERS; c++) begin : gen_cluster_state
    // Empty register and a spare slot
    assign avail[c]    = !valid_q[c] && (used_q[c] < SLOTS_PER_CLUSTER[SLOT_CNT_W-1:0]);
    assign in_use[c]   = (used_q[c] != '0);
    assign take_vec[c] = take && (target == CLUSTER_IDX_W'(c));
    assign free_vec[c] = slot_free_valid_i && (slot_free_cluster_i == CLUSTER_IDX_W'(c));
  end

  // Lowest available cluster index
  always_comb begin
    target = '0;
    for (int c = NUM_CLUSTERS - 1; c >= 0; c--) begin
      if (avail[c]) begin
        target = CLUSTER_IDX_W'(c);
      end
    end
  end

  assign task_ready_o = |avail;
  assign take         = task_valid_i && task_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      active_q <= 1'b0;
      for (int c = 0; c < NUM_CLUSTERS; c++) begin
        used_q[c] <= '0;
      end
    end else begin
      for (int c = 0; c < NUM_CLUSTERS; c++) begin
        if (take_vec[c]) begin
          valid_q[c] <= 1'b1;
        end else if (cluster_task_ready_i[c]) begin
          valid_q[c] <= 1'b0;
        end
        // Take and release in one cycle cancel out
        case ({take_vec[c], free_vec[c]})
          2'b10: used_q[c] <= used_q[c] + 1'b1;
          2'b01: begin
            if (in_use[c]) begin
              used_q[c] <= used_q[c] - 1'b1;
            end
          end
          default: used_q[c] <= used_q[c];
        endcase
      end
      active_q <= &in_use;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      mpq_q[target]  <= task_mpq_i;
      addr_q[target] <= task_addr_i;
      len_q[target]  <= task_len_i;
    end
  end

  assign cluster_task_valid_o = valid_q;
  assign cluster_task_mpq_o   = mpq_q;
  assign cluster_task_addr_o  = addr_q;
  assign cluster_task_len_o   = len_q;
  assign pspin_active_o       = active_q;

endmodule

// ==== verilog/her_intake.sv ====
`timescale 1ns/1ps
// ******************************
// HER intake
// Per-MPQ circular queues with
// full flags and round-robin
// selection of the next task
// ******************************

module her_intake import pspin_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // HERs from the NIC
  input  logic                  her_valid_i,
  input  logic [MPQ_IDX_W-1:0]  her_mpq_i,
  input  logic [PKT_ADDR_W-1:0] her_addr_i,
  input  logic [PKT_LEN_W-1:0]  her_len_i,
  output logic                  her_ready_o,
  output logic [NUM_MPQ-1:0]    mpq_full_o,
  // Tasks to the scheduler
  output logic                  task_valid_o,
  input  logic                  task_ready_i,
  output logic [MPQ_IDX_W-1:0]  task_mpq_o,
  output logic [PKT_ADDR_W-1:0] task_addr_o,
  output logic [PKT_LEN_W-1:0]  task_len_o
);

  logic [PKT_ADDR_W-1:0]          addr_mem [NUM_MPQ][MPQ_DEPTH];
  logic [PKT_LEN_W-1:0]           len_mem  [NUM_MPQ][MPQ_DEPTH];
  logic [$clog2(MPQ_DEPTH)-1:0]   wr_ptr_q [NUM_MPQ];
  logic [$clog2(MPQ_DEPTH)-1:0]   rd_ptr_q [NUM_MPQ];
  logic [$clog2(MPQ_DEPTH+1)-1:0] fill_q   [NUM_MPQ];

  logic [NUM_MPQ-1:0]   not_empty;
  logic [NUM_MPQ-1:0]   push_vec;
  logic [NUM_MPQ-1:0]   pop_vec;
  logic [MPQ_IDX_W-1:0] last_q;
  logic [MPQ_IDX_W-1:0] sel;
  logic                 push;
  logic                 pop;

  for (genvar i = 0; i < NUM_MPQ; i++) begin : gen_mpq_flags
    assign mpq_full_o[i] = (fill_q[i] == MPQ_DEPTH[$clog2(MPQ_DEPTH+1)-1:0]);
    assign not_empty[i]  = (fill_q[i] != '0);
    assign push_vec[i]   = push && (her_mpq_i == MPQ_IDX_W'(i));
    assign pop_vec[i]    = pop && (sel == MPQ_IDX_W'(i));
  end

  // Ready only looks at the addressed queue
  assign her_ready_o = !mpq_full_o[her_mpq_i];
  assign push        = her_valid_i && her_ready_o;

  // Search starts one past the MPQ served last, lowest offset wins
  always_comb begin
    logic [MPQ_IDX_W-1:0] idx;
    sel = last_q;
    idx = last_q;
    for (int k = NUM_MPQ; k >= 1; k--) begin
      idx = last_q + MPQ_IDX_W'(k);
      if (not_empty[idx]) begin
        sel = idx;
      end
    end
  end

  assign task_valid_o = |not_empty;
  assign task_mpq_o   = sel;
  assign task_addr_o  = addr_mem[sel][rd_ptr_q[sel]];
  assign task_len_o   = len_mem[sel][rd_ptr_q[sel]];
  assign pop          = task_valid_o && task_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_MPQ; i++) begin
        wr_ptr_q[i] <= '0;
        rd_ptr_q[i] <= '0;
        fill_q[i]   <= '0;
      end
      // First search then begins at MPQ 0
      last_q <= MPQ_IDX_W'(NUM_MPQ - 1);
    end else begin
      for (int i = 0; i < NUM_MPQ; i++) begin
        if (push_vec[i]) begin
          wr_ptr_q[i] <= wr_ptr_q[i] + 1'b1;
        end
        if (pop_vec[i]) begin
          rd_ptr_q[i] <= rd_ptr_q[i] + 1'b1;
        end
        case ({push_vec[i], pop_vec[i]})
          2'b10:   fill_q[i] <= fill_q[i] + 1'b1;
          2'b01:   fill_q[i] <= fill_q[i] - 1'b1;
          default: fill_q[i] <= fill_q[i];
        endcase
      end
      if (pop) begin
        last_q <= sel;
      end
    end
  end

  // Descriptor storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      addr_mem[her_mpq_i][wr_ptr_q[her_mpq_i]] <= her_addr_i;
      len_mem[her_mpq_i][wr_ptr_q[her_mpq_i]]  <= her_len_i;
    end
  end

endmodule

// ==== verilog/pspin_pkg.sv ====
// ******************************
// Packet handler dispatch core
// Sizes and widths shared by the
// intake, scheduler and arbiter
// ******************************

package pspin_pkg;

  // Processing clusters seen as external task ports
  localparam int unsigned NUM_CLUSTERS = 4;

  // Message processing queues and their depth
  localparam int unsigned NUM_MPQ = 4;
  localparam int unsigned MPQ_DEPTH = 4;

  // Handler slots a cluster may hold before it returns feedback
  localparam int unsigned SLOTS_PER_CLUSTER = 2;

  // Index and counter widths
  localparam int unsigned MPQ_IDX_W = $clog2(NUM_MPQ);
  localparam int unsigned CLUSTER_IDX_W = $clog2(NUM_CLUSTERS);
  localparam int unsigned SLOT_CNT_W = $clog2(SLOTS_PER_CLUSTER + 1);

  // Packet descriptor fields, address in L2 and length in bytes
  localparam int unsigned PKT_ADDR_W = 16;
  localparam int unsigned PKT_LEN_W = 12;

endpackage
